//--- include/hart_defs.svh
`ifndef HART_DEFS_SVH
`define HART_DEFS_SVH

// Word widths
`define HART_XLEN 32
`define HART_ILEN 32

// ROM at the reset vector, RAM above it and MMIO on top
`define HART_RESET_VECTOR 32'h0001_0000
`define HART_RAM_BASE 32'h0002_0000
`define HART_MMIO_BASE 32'h0003_0000

// Depths in words
`define HART_ROM_WORDS 64
`define HART_RAM_WORDS 64

`endif

//--- hw/isa_pkg.sv
`default_nettype none

`include "hart_defs.svh"

package isa_pkg;

    typedef logic [`HART_XLEN-1:0] word_t;
    typedef logic [`HART_ILEN-1:0] instr_t;
    typedef logic [4:0] reg_index_t;

    // Major opcodes kept by this hart
    typedef enum logic [6:0] {
        OPCODE_OP      = 7'b0110011,
        OPCODE_OP_IMM  = 7'b0010011,
        OPCODE_LOAD    = 7'b0000011,
        OPCODE_STORE   = 7'b0100011,
        OPCODE_BRANCH  = 7'b1100011,
        OPCODE_JAL     = 7'b1101111,
        OPCODE_UNKNOWN = 7'b0000000
    } opcode_t;

    typedef enum logic {
        ALU_ADD,
        ALU_SUB
    } alu_op_t;

endpackage

`default_nettype wire

//--- hw/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // What the memory stage does with the computed address
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_t;

    typedef enum logic {
        WB_FROM_COMPUTE,
        WB_FROM_MEMORY
    } wb_source_t;

endpackage

`default_nettype wire

//--- hw/instruction_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module instruction_decoder (
    input  isa_pkg::instr_t       instr_bits,
    output logic                  legal,
    output logic                  reg_write,
    output logic                  uses_imm,
    output logic                  is_branch,
    output logic                  is_jal,
    output isa_pkg::reg_index_t   rs1,
    output isa_pkg::reg_index_t   rs2,
    output isa_pkg::reg_index_t   rd,
    output isa_pkg::word_t        imm,
    output isa_pkg::alu_op_t      alu_op,
    output pipe_pkg::mem_op_t     mem_op,
    output pipe_pkg::wb_source_t  wb_source
);
    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_t opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic writes_rd;
    word_t imm_i, imm_s, imm_b, imm_j;

    assign funct3 = instr_bits[14:12];
    assign funct7 = instr_bits[31:25];
    assign rd = instr_bits[11:7];

    assign imm_i = {{20{instr_bits[31]}}, instr_bits[31:20]};
    assign imm_s = {{20{instr_bits[31]}}, instr_bits[31:25], instr_bits[11:7]};
    assign imm_b = {{19{instr_bits[31]}}, instr_bits[31], instr_bits[7],
                    instr_bits[30:25], instr_bits[11:8], 1'b0};
    assign imm_j = {{11{instr_bits[31]}}, instr_bits[31], instr_bits[19:12],
                    instr_bits[20], instr_bits[30:21], 1'b0};

    // Writes to x0 are dropped here so no later stage sees them
    assign reg_write = legal && writes_rd && (rd != '0);

    always_comb begin
        case (instr_bits[6:0])
            OPCODE_OP, OPCODE_OP_IMM, OPCODE_LOAD, OPCODE_STORE, OPCODE_BRANCH, OPCODE_JAL:
                opcode = opcode_t'(instr_bits[6:0]);
            default:
                opcode = OPCODE_UNKNOWN;
        endcase
    end

    // Unused source fields stay at x0 so they never match a writer
    always_comb begin
        legal = 1'b0;
        writes_rd = 1'b0;
        uses_imm = 1'b0;
        is_branch = 1'b0;
        is_jal = 1'b0;
        rs1 = '0;
        rs2 = '0;
        imm = '0;
        alu_op = ALU_ADD;
        mem_op = MEM_NONE;
        wb_source = WB_FROM_COMPUTE;
        case (opcode)
            OPCODE_OP: begin
                legal = (funct3 == 3'b000) && (funct7 == 7'h00 || funct7 == 7'h20);
                writes_rd = 1'b1;
                rs1 = instr_bits[19:15];
                rs2 = instr_bits[24:20];
                alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
            end
            OPCODE_OP_IMM: begin
                legal = (funct3 == 3'b000);
                writes_rd = 1'b1;
                rs1 = instr_bits[19:15];
                uses_imm = 1'b1;
                imm = imm_i;
            end
            OPCODE_LOAD: begin
                legal = (funct3 == 3'b010);
                writes_rd = 1'b1;
                rs1 = instr_bits[19:15];
                uses_imm = 1'b1;
                imm = imm_i;
                mem_op = MEM_LOAD;
                wb_source = WB_FROM_MEMORY;
            end
            OPCODE_STORE: begin
                legal = (funct3 == 3'b010);
                rs1 = instr_bits[19:15];
                rs2 = instr_bits[24:20];
                uses_imm = 1'b1;
                imm = imm_s;
                mem_op = MEM_STORE;
            end
            OPCODE_BRANCH: begin
                // BEQ only
                legal = (funct3 == 3'b000);
                rs1 = instr_bits[19:15];
                rs2 = instr_bits[24:20];
                is_branch = 1'b1;
                imm = imm_b;
            end
            OPCODE_JAL: begin
                legal = 1'b1;
                writes_rd = 1'b1;
                is_jal = 1'b1;
                imm = imm_j;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 w_enable,
    input  isa_pkg::reg_index_t  rs1,
    input  isa_pkg::reg_index_t  rs2,
    input  isa_pkg::reg_index_t  w_reg,
    input  isa_pkg::word_t       w_data,
    output isa_pkg::word_t       rs1_val,
    output isa_pkg::word_t       rs2_val
);
    import isa_pkg::*;

    word_t regs [32];
    logic do_write;

    // x0 is never written and keeps its reset value of zero
    assign do_write = w_enable && (w_reg != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
            rs1_val <= '0;
            rs2_val <= '0;
        end else begin
            if (do_write) begin
                regs[w_reg] <= w_data;
            end
            // Write-first reads see the writeback stage in the same cycle
            if (do_write && w_reg == rs1) begin
                rs1_val <= w_data;
            end else begin
                rs1_val <= regs[rs1];
            end
            if (do_write && w_reg == rs2) begin
                rs2_val <= w_data;
            end else begin
                rs2_val <= regs[rs2];
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset) rs1 == '0 |=> rs1_val == '0);

endmodule

`default_nettype wire

//--- hw/operand_forwarder.sv
`timescale 1ns/1ns
`default_nettype none

module operand_forwarder (
    input  isa_pkg::reg_index_t   rs,
    input  isa_pkg::word_t        rf_value,
    input  isa_pkg::word_t        mem_stage_result,
    input  isa_pkg::word_t        wb_stage_result,
    input  isa_pkg::word_t        wb_mem_data,
    input  logic                  mem_stage_valid,
    input  logic                  mem_stage_reg_write,
    input  logic                  wb_stage_valid,
    input  logic                  wb_stage_reg_write,
    input  isa_pkg::reg_index_t   mem_stage_rd,
    input  isa_pkg::reg_index_t   wb_stage_rd,
    input  pipe_pkg::mem_op_t     mem_stage_mem_op,
    input  pipe_pkg::wb_source_t  wb_stage_source,
    output logic                  ready,
    output isa_pkg::word_t        operand
);
    import pipe_pkg::*;

    logic mem_hit, wb_hit;

    // reg_write is never set for x0, so x0 cannot hit
    assign mem_hit = mem_stage_valid && mem_stage_reg_write && (mem_stage_rd == rs);
    assign wb_hit = wb_stage_valid && wb_stage_reg_write && (wb_stage_rd == rs);

    // A load in the memory stage has no data until writeback
    assign ready = !(mem_hit && mem_stage_mem_op == MEM_LOAD);

    always_comb begin
        if (mem_hit) begin
            operand = mem_stage_result;
        end else if (wb_hit) begin
            operand = (wb_stage_source == WB_FROM_MEMORY) ? wb_mem_data : wb_stage_result;
        end else begin
            operand = rf_value;
        end
    end

endmodule

`default_nettype wire

//--- hw/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
    input  logic              enable,
    input  isa_pkg::word_t    pc,
    input  isa_pkg::word_t    rs1_val,
    input  isa_pkg::word_t    rs2_val,
    input  isa_pkg::word_t    imm,
    input  isa_pkg::alu_op_t  alu_op,
    input  logic              uses_imm,
    input  logic              is_branch,
    input  logic              is_jal,
    output isa_pkg::word_t    result,
    output isa_pkg::word_t    jump_target,
    output logic              jump
);
    import isa_pkg::*;

    word_t operand_b;

    assign operand_b = uses_imm ? imm : rs2_val;

    // JAL links the return address
    always_comb begin
        if (is_jal) begin
            result = pc + 32'd4;
        end else if (alu_op == ALU_SUB) begin
            result = rs1_val - operand_b;
        end else begin
            result = rs1_val + operand_b;
        end
    end

    // Same target adder for BEQ and JAL
    assign jump_target = pc + imm;
    assign jump = enable && (is_jal || (is_branch && rs1_val == rs2_val));

endmodule

`default_nettype wire

//--- hw/data_memory.sv
`timescale 1ns/1ns
`default_nettype none

`include "hart_defs.svh"

module data_memory (
    input  logic               clock,
    input  logic               valid,
    input  pipe_pkg::mem_op_t  mem_op,
    input  isa_pkg::word_t     addr,
    input  isa_pkg::word_t     w_data,
    output isa_pkg::word_t     r_data,
    output isa_pkg::word_t     mmio_addr,
    output isa_pkg::word_t     mmio_w_data,
    output logic               mmio_w_enable
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int RAM_INDEX_W = $clog2(`HART_RAM_WORDS);

    word_t ram [`HART_RAM_WORDS];
    word_t ram_offset;
    logic [RAM_INDEX_W-1:0] ram_index;
    logic is_store, is_mmio;

    // RAM is word addressed from its base
    assign ram_offset = addr - `HART_RAM_BASE;
    assign ram_index = ram_offset[RAM_INDEX_W+1:2];
    assign is_store = valid && (mem_op == MEM_STORE);
    assign is_mmio = (addr >= `HART_MMIO_BASE);

    always_ff @(posedge clock) begin
        if (is_store && !is_mmio) begin
            ram[ram_index] <= w_data;
        end
        r_data <= ram[ram_index];
    end

    // MMIO stores leave the hart in the same cycle
    assign mmio_w_enable = is_store && is_mmio;
    assign mmio_addr = addr;
    assign mmio_w_data = w_data;

    assert property (@(posedge clock) valid && mem_op != MEM_NONE |-> addr[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hw/hart.sv
`timescale 1ns/1ns
`default_nettype none

`include "hart_defs.svh"

module hart (
    input  logic            clock,
    input  logic            reset,
    output logic            mmio_w_enable,
    output isa_pkg::word_t  mmio_addr,
    output isa_pkg::word_t  mmio_w_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int ROM_INDEX_W = $clog2(`HART_ROM_WORDS);

    instr_t rom [`HART_ROM_WORDS];
    word_t pc, next_pc, rom_offset, jump_target;
    logic stall, jump;

    logic s2_valid;
    word_t s2_pc;
    instr_t s2_instr;
    logic d_legal, d_reg_write, d_uses_imm, d_is_branch, d_is_jal;
    reg_index_t d_rs1, d_rs2, d_rd, rf_rs1, rf_rs2;
    word_t d_imm;
    alu_op_t d_alu_op;
    mem_op_t d_mem_op;
    wb_source_t d_wb_source;

    logic s3_valid, s3_reg_write, s3_uses_imm, s3_is_branch, s3_is_jal;
    word_t s3_pc, s3_imm;
    reg_index_t s3_rs1, s3_rs2, s3_rd;
    alu_op_t s3_alu_op;
    mem_op_t s3_mem_op;
    wb_source_t s3_wb_source;
    word_t rf_rs1_val, rf_rs2_val, rs1_operand, rs2_operand, ex_result;
    logic rs1_ready, rs2_ready;

    logic s4_valid, s4_reg_write;
    reg_index_t s4_rd;
    word_t s4_result, s4_store_data;
    mem_op_t s4_mem_op;
    wb_source_t s4_wb_source;

    logic s5_valid, s5_reg_write;
    reg_index_t s5_rd;
    word_t s5_result, mem_r_data, wb_value;
    wb_source_t s5_wb_source;

    initial begin
        $readmemh("verif/program.hex", rom);
    end

    // The ROM starts at the reset vector
    assign rom_offset = pc - `HART_RESET_VECTOR;
    assign stall = s3_valid && (!rs1_ready || !rs2_ready);

    always_comb begin
        if (jump) begin
            next_pc = jump_target;
        end else if (stall) begin
            next_pc = pc;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    // Valid bits; a jump squashes what enters stages 2 and 3
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= `HART_RESET_VECTOR;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
            s4_valid <= 1'b0;
            s5_valid <= 1'b0;
        end else begin
            pc <= next_pc;
            if (!stall) begin
                s2_valid <= !jump;
                s3_valid <= s2_valid && d_legal && !jump;
            end
            s4_valid <= s3_valid && !stall;
            s5_valid <= s4_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            s2_instr <= rom[rom_offset[ROM_INDEX_W+1:2]];
            s2_pc <= pc;
            s3_pc <= s2_pc;
            s3_rs1 <= d_rs1;
            s3_rs2 <= d_rs2;
            s3_rd <= d_rd;
            s3_imm <= d_imm;
            s3_alu_op <= d_alu_op;
            s3_uses_imm <= d_uses_imm;
            s3_is_branch <= d_is_branch;
            s3_is_jal <= d_is_jal;
            s3_reg_write <= d_reg_write;
            s3_mem_op <= d_mem_op;
            s3_wb_source <= d_wb_source;
        end
        s4_result <= ex_result;
        s4_store_data <= rs2_operand;
        s4_rd <= s3_rd;
        s4_reg_write <= s3_reg_write;
        s4_mem_op <= s3_mem_op;
        s4_wb_source <= s3_wb_source;
        s5_result <= s4_result;
        s5_rd <= s4_rd;
        s5_reg_write <= s4_reg_write;
        s5_wb_source <= s4_wb_source;
    end

    instruction_decoder decoder (
        .instr_bits (s2_instr),
        .legal      (d_legal),
        .reg_write  (d_reg_write),
        .uses_imm   (d_uses_imm),
        .is_branch  (d_is_branch),
        .is_jal     (d_is_jal),
        .rs1        (d_rs1),
        .rs2        (d_rs2),
        .rd         (d_rd),
        .imm        (d_imm),
        .alu_op     (d_alu_op),
        .mem_op     (d_mem_op),
        .wb_source  (d_wb_source)
    );

    // A held compute instruction re-reads its own operands
    assign rf_rs1 = stall ? s3_rs1 : d_rs1;
    assign rf_rs2 = stall ? s3_rs2 : d_rs2;
    assign wb_value = (s5_wb_source == WB_FROM_MEMORY) ? mem_r_data : s5_result;

    register_file regfile (
        .clock    (clock),
        .reset    (reset),
        .w_enable (s5_valid && s5_reg_write),
        .rs1      (rf_rs1),
        .rs2      (rf_rs2),
        .w_reg    (s5_rd),
        .w_data   (wb_value),
        .rs1_val  (rf_rs1_val),
        .rs2_val  (rf_rs2_val)
    );

    operand_forwarder rs1_forwarder (
        .rs                  (s3_rs1),
        .rf_value            (rf_rs1_val),
        .mem_stage_result    (s4_result),
        .wb_stage_result     (s5_result),
        .wb_mem_data         (mem_r_data),
        .mem_stage_valid     (s4_valid),
        .mem_stage_reg_write (s4_reg_write),
        .wb_stage_valid      (s5_valid),
        .wb_stage_reg_write  (s5_reg_write),
        .mem_stage_rd        (s4_rd),
        .wb_stage_rd         (s5_rd),
        .mem_stage_mem_op    (s4_mem_op),
        .wb_stage_source     (s5_wb_source),
        .ready               (rs1_ready),
        .operand             (rs1_operand)
    );

    operand_forwarder rs2_forwarder (
        .rs                  (s3_rs2),
        .rf_value            (rf_rs2_val),
        .mem_stage_result    (s4_result),
        .wb_stage_result     (s5_result),
        .wb_mem_data         (mem_r_data),
        .mem_stage_valid     (s4_valid),
        .mem_stage_reg_write (s4_reg_write),
        .wb_stage_valid      (s5_valid),
        .wb_stage_reg_write  (s5_reg_write),
        .mem_stage_rd        (s4_rd),
        .wb_stage_rd         (s5_rd),
        .mem_stage_mem_op    (s4_mem_op),
        .wb_stage_source     (s5_wb_source),
        .ready               (rs2_ready),
        .operand             (rs2_operand)
    );

    execute_unit compute (
        .enable      (s3_valid && !stall),
        .pc          (s3_pc),
        .rs1_val     (rs1_operand),
        .rs2_val     (rs2_operand),
        .imm         (s3_imm),
        .alu_op      (s3_alu_op),
        .uses_imm    (s3_uses_imm),
        .is_branch   (s3_is_branch),
        .is_jal      (s3_is_jal),
        .result      (ex_result),
        .jump_target (jump_target),
        .jump        (jump)
    );

    data_memory dmem (
        .clock         (clock),
        .valid         (s4_valid),
        .mem_op        (s4_mem_op),
        .addr          (s4_result),
        .w_data        (s4_store_data),
        .r_data        (mem_r_data),
        .mmio_addr     (mmio_addr),
        .mmio_w_data   (mmio_w_data),
        .mmio_w_enable (mmio_w_enable)
    );

    // The bubble sent to stage 4 clears a load-use stall after one cycle
    assert property (@(posedge clock) disable iff (reset) stall |=> !stall);

endmodule

`default_nettype wire

//--- verif/hart_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "hart_defs.svh"

module hart_tb;
    import isa_pkg::*;

    localparam int RESULT_STORES = 7;
    // Program is 34 words, so five times that plus every stall and squash fits
    localparam int TIMEOUT_CYCLES = 300;
    localparam word_t DONE_ADDR = `HART_MMIO_BASE + 32'h100;
    localparam word_t POISON = 32'h0000_0666;

    logic clock = 1'b0;
    logic reset;
    logic mmio_w_enable;
    word_t mmio_addr;
    word_t mmio_w_data;

    // Seven result stores, then the done store in the last slot
    word_t expected_addr [8];
    word_t expected_data [8];
    word_t next_addr;
    word_t next_data;
    logic [2:0] pulse_index;
    logic done_seen = 1'b0;
    logic timed_out = 1'b0;
    int cycle_count = 0;
    int mismatch_count = 0;
    int failure_count = 0;

    hart UUT (
        .clock         (clock),
        .reset         (reset),
        .mmio_w_enable (mmio_w_enable),
        .mmio_addr     (mmio_addr),
        .mmio_w_data   (mmio_w_data)
    );

    always #5 clock = ~clock;

    assign next_addr = expected_addr[pulse_index];
    assign next_data = expected_data[pulse_index];

    always @(posedge clock) begin
        if (reset) begin
            pulse_index <= '0;
            done_seen <= 1'b0;
        end else if (mmio_w_enable) begin
            if (mmio_addr == DONE_ADDR) begin
                done_seen <= 1'b1;
            end else begin
                pulse_index <= pulse_index + 3'd1;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            timed_out <= 1'b1;
        end
    end

    assert property (@(posedge clock) reset && cycle_count > 0 |-> !mmio_w_enable)
        else begin
            failure_count = failure_count + 1;
            $display("Store pulse at %0t while reset is held", $time);
        end

    assert property (@(posedge clock) disable iff (reset) mmio_w_enable |-> mmio_addr == next_addr)
        else begin
            mismatch_count = mismatch_count + 1;
            $display("Mismatch at %0t: mmio_addr expected %h, got %h",
                $time, $sampled(next_addr), $sampled(mmio_addr));
        end

    assert property (@(posedge clock) disable iff (reset)
        mmio_w_enable |-> mmio_w_data == next_data)
        else begin
            mismatch_count = mismatch_count + 1;
            $display("Mismatch at %0t: mmio_w_data expected %h, got %h",
                $time, $sampled(next_data), $sampled(mmio_w_data));
        end

    assert property (@(posedge clock) disable iff (reset)
        mmio_w_enable && mmio_addr != DONE_ADDR |-> pulse_index != 3'd7)
        else begin
            failure_count = failure_count + 1;
            $display("More result stores at %0t than the program makes", $time);
        end

    // Squashed stores would carry the poison value
    assert property (@(posedge clock) disable iff (reset) mmio_w_enable |-> mmio_w_data != POISON)
        else begin
            failure_count = failure_count + 1;
            $display("Poison value stored at %0t, a skipped instruction ran", $time);
        end

    assert property (@(posedge clock) disable iff (reset)
        mmio_w_enable && mmio_addr == DONE_ADDR |-> pulse_index == 3'(RESULT_STORES))
        else begin
            failure_count = failure_count + 1;
            $display("Done store came after %0d of %0d result stores",
                $sampled(pulse_index), RESULT_STORES);
        end

    assert property (@(posedge clock) disable iff (reset) done_seen |-> !mmio_w_enable)
        else begin
            failure_count = failure_count + 1;
            $display("Store pulse at %0t after the done store", $time);
        end

    initial begin
        reset = 1'b1;
        // Worked out by hand from program.hex
        expected_addr[0] = `HART_MMIO_BASE + 32'd0;
        expected_data[0] = 32'd42 + 32'd25;
        expected_addr[1] = `HART_MMIO_BASE + 32'd4;
        expected_data[1] = 32'd42 - 32'd67;
        expected_addr[2] = `HART_MMIO_BASE + 32'd8;
        expected_data[2] = 32'd42;
        // Loaded 100 plus x7
        expected_addr[3] = `HART_MMIO_BASE + 32'd12;
        expected_data[3] = 32'd100 + 32'd67;
        expected_addr[4] = `HART_MMIO_BASE + 32'd16;
        expected_data[4] = 32'd25;
        // JAL sits at ROM offset 0x68
        expected_addr[5] = `HART_MMIO_BASE + 32'd20;
        expected_data[5] = `HART_RESET_VECTOR + 32'h68 + 32'd4;
        expected_addr[6] = `HART_MMIO_BASE + 32'd24;
        expected_data[6] = 32'd42;
        expected_addr[7] = DONE_ADDR;
        expected_data[7] = 32'd0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        wait (done_seen || timed_out);
        // A few more edges so late pulses still meet the checks
        repeat (4) @(posedge clock);
        if (timed_out) begin
            failure_count = failure_count + 1;
            $display("Timeout: no done store within %0d cycles", TIMEOUT_CYCLES);
        end
        $display("Summary: %0d mismatches, %0d other failures, %0d of %0d result stores",
            mismatch_count, failure_count, pulse_index, RESULT_STORES);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/program.hex
// One 32-bit instruction word per line, in address order from the reset vector
// Text after each word gives its ROM offset and assembly
40000093 // 00 addi x1, x0, 1024
001080B3 // 04 add  x1, x1, x1
001080B3 // 08 add  x1, x1, x1
001080B3 // 0c add  x1, x1, x1
001080B3 // 10 add  x1, x1, x1
001080B3 // 14 add  x1, x1, x1
001080B3 // 18 add  x1, x1, x1      x1 = 0x10000
00108133 // 1c add  x2, x1, x1      RAM base
001101B3 // 20 add  x3, x2, x1      MMIO base
66600613 // 24 addi x12, x0, 0x666  poison
01900293 // 28 addi x5, x0, 25
01128313 // 2c addi x6, x5, 17
005303B3 // 30 add  x7, x6, x5
40730433 // 34 sub  x8, x6, x7
0071A023 // 38 sw   x7, 0(x3)
0081A223 // 3c sw   x8, 4(x3)
0061A423 // 40 sw   x6, 8(x3)
06400493 // 44 addi x9, x0, 100
00912823 // 48 sw   x9, 16(x2)
01012503 // 4c lw   x10, 16(x2)
007505B3 // 50 add  x11, x10, x7
00B1A623 // 54 sw   x11, 12(x3)
00528663 // 58 beq  x5, x5, +12
00C1A823 // 5c sw   x12, 16(x3)
00C1A823 // 60 sw   x12, 16(x3)
0051A823 // 64 sw   x5, 16(x3)
00C006EF // 68 jal  x13, +12
00C1AA23 // 6c sw   x12, 20(x3)
00C1AA23 // 70 sw   x12, 20(x3)
00D1AA23 // 74 sw   x13, 20(x3)
00628463 // 78 beq  x5, x6, +8
0061AC23 // 7c sw   x6, 24(x3)
1001A023 // 80 sw   x0, 256(x3)     done
0000006F // 84 jal  x0, 0

//--- vlog.f
+incdir+include
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/instruction_decoder.sv
hw/register_file.sv
hw/operand_forwarder.sv
hw/execute_unit.sv
hw/data_memory.sv
hw/hart.sv
verif/hart_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := hart_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
